/* run_sim.sh */
#!/bin/sh
# build and run the sliding-window testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_swu -f tb.f -o tb_swu_sim
./obj_dir/tb_swu_sim | tee sim.log

if grep -q "^sim passed$" sim.log; then
   echo "result: PASS"
   exit 0
else
   echo "result: FAIL"
   exit 1
fi

/* source/swu_config.svh */
`ifndef SWU_CONFIG_SVH
`define SWU_CONFIG_SVH

// input feature map geometry
`define SWU_IFM_WIDTH   5
`define SWU_IFM_HEIGHT  5
`define SWU_CHANNELS    2
`define SWU_WORD_BITS   8

// kernel and stride
`define SWU_KERNEL_H    3
`define SWU_KERNEL_W    3
`define SWU_STRIDE      1

// derived output size
`define SWU_OFM_WIDTH   (((`SWU_IFM_WIDTH - `SWU_KERNEL_W) / `SWU_STRIDE) + 1)
`define SWU_OFM_HEIGHT  (((`SWU_IFM_HEIGHT - `SWU_KERNEL_H) / `SWU_STRIDE) + 1)

// one buffer row per kernel row
`define SWU_BUF_WORDS   (`SWU_KERNEL_H * `SWU_IFM_WIDTH * `SWU_CHANNELS)

`endif

/* source/swu_out_stage.sv */
`timescale 1ns/1ps

module swu_out_stage (
   input  logic                clk,
   input  logic                resetn,
   input  swu_pkg::rd_issue_t  rd_issue_i,
   input  swu_pkg::data_word_t rd_data_i,
   output logic                issue_ok_o,
   output swu_pkg::data_word_t out_data_o,
   output logic                out_valid_o,
   input  logic                out_ready_i
);

   logic ram_vld;
   logic advance;

   // output register is free or being taken this cycle
   assign advance = !out_valid_o || out_ready_i;

   // a new read may overwrite the RAM register only if its item moves on
   assign issue_ok_o = advance || !ram_vld;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         ram_vld     <= 1'b0;
         out_valid_o <= 1'b0;
      end else begin
         if (advance) begin
            out_valid_o <= ram_vld;
         end
         if (rd_issue_i.valid) begin
            ram_vld <= 1'b1;
         end else if (advance) begin
            ram_vld <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (advance && ram_vld) begin
         out_data_o <= rd_data_i;
      end
   end

endmodule

/* source/swu_pkg.sv */
`include "swu_config.svh"

package swu_pkg;

   typedef logic [`SWU_WORD_BITS-1:0]              data_word_t;
   typedef logic [$clog2(`SWU_BUF_WORDS)-1:0]      buf_addr_t;

   // image row modulo kernel height
   typedef logic [$clog2(`SWU_KERNEL_H+1)-1:0]     row_slot_t;

   typedef logic [$clog2(`SWU_IFM_HEIGHT+1)-1:0]   img_row_t;
   typedef logic [$clog2(`SWU_IFM_WIDTH+1)-1:0]    img_col_t;
   typedef logic [$clog2(`SWU_OFM_HEIGHT+1)-1:0]   ofm_row_t;
   typedef logic [$clog2(`SWU_OFM_WIDTH+1)-1:0]    ofm_col_t;
   typedef logic [$clog2(`SWU_KERNEL_H+1)-1:0]     kern_row_t;
   typedef logic [$clog2(`SWU_KERNEL_W+1)-1:0]     kern_col_t;
   typedef logic [$clog2(`SWU_CHANNELS+1)-1:0]     chan_t;

   typedef struct packed {
      logic      valid;
      buf_addr_t addr;
   } rd_issue_t;

   typedef enum logic {
      FILL,
      WAIT_FRAME
   } wr_state_t;

endpackage

/* source/swu_read_ctrl.sv */
`timescale 1ns/1ps
`include "swu_config.svh"

module swu_read_ctrl (
   input  logic               clk,
   input  logic               resetn,
   input  swu_pkg::img_row_t  rows_written_i,
   input  logic               issue_ok_i,
   output swu_pkg::rd_issue_t rd_issue_o,
   output swu_pkg::img_row_t  oldest_row_o,
   output logic               frame_done_o
);

   localparam int KH        = `SWU_KERNEL_H;
   localparam int KW        = `SWU_KERNEL_W;
   localparam int CH        = `SWU_CHANNELS;
   localparam int STRIDE    = `SWU_STRIDE;
   localparam int ROW_WORDS = `SWU_IFM_WIDTH * `SWU_CHANNELS;

   swu_pkg::chan_t     chan;
   swu_pkg::kern_col_t kcol;
   swu_pkg::kern_row_t krow;
   swu_pkg::ofm_col_t  ocol;
   swu_pkg::ofm_row_t  orow;
   swu_pkg::row_slot_t base_slot;
   swu_pkg::row_slot_t next_base;
   swu_pkg::row_slot_t rd_slot;
   swu_pkg::img_row_t  oldest;
   int                 slot_sum;
   int                 base_sum;
   logic               avail;
   logic               issue;
   logic               last_chan;
   logic               last_kcol;
   logic               last_krow;
   logic               last_ocol;
   logic               last_orow;

   assign last_chan = (chan == swu_pkg::chan_t'(CH - 1));
   assign last_kcol = (kcol == swu_pkg::kern_col_t'(KW - 1));
   assign last_krow = (krow == swu_pkg::kern_row_t'(KH - 1));
   assign last_ocol = (ocol == swu_pkg::ofm_col_t'(`SWU_OFM_WIDTH - 1));
   assign last_orow = (orow == swu_pkg::ofm_row_t'(`SWU_OFM_HEIGHT - 1));

   ////////////////////
   // slot arithmetic, wraps at kernel height

   always_comb begin
      slot_sum = int'(base_slot) + int'(krow);
      if (slot_sum >= KH) begin
         slot_sum = slot_sum - KH;
      end
      rd_slot = swu_pkg::row_slot_t'(slot_sum);

      base_sum = int'(base_slot) + (STRIDE % KH);
      if (base_sum >= KH) begin
         base_sum = base_sum - KH;
      end
      next_base = swu_pkg::row_slot_t'(base_sum);
   end

   // last input row of this output row must be complete
   assign avail = int'(rows_written_i) > int'(oldest) + KH - 1;
   assign issue = avail && issue_ok_i;

   always_comb begin
      rd_issue_o.valid = issue;
      rd_issue_o.addr  = swu_pkg::buf_addr_t'(int'(rd_slot) * ROW_WORDS +
                         (int'(ocol) * STRIDE + int'(kcol)) * CH + int'(chan));
   end

   assign oldest_row_o = oldest;
   assign frame_done_o = issue && last_chan && last_kcol && last_krow &&
                         last_ocol && last_orow;

   ////////////////////
   // window counters

   always_ff @(posedge clk) begin
      if (!resetn) begin
         chan      <= '0;
         kcol      <= '0;
         krow      <= '0;
         ocol      <= '0;
         orow      <= '0;
         base_slot <= '0;
         oldest    <= '0;
      end else if (issue) begin
         chan <= last_chan ? '0 : chan + 1'b1;
         if (last_chan) begin
            kcol <= last_kcol ? '0 : kcol + 1'b1;
            if (last_kcol) begin
               krow <= last_krow ? '0 : krow + 1'b1;
               if (last_krow) begin
                  ocol <= last_ocol ? '0 : ocol + 1'b1;
                  if (last_ocol) begin
                     if (last_orow) begin
                        orow      <= '0;
                        oldest    <= '0;
                        base_slot <= '0;
                     end else begin
                        orow      <= orow + 1'b1;
                        oldest    <= oldest + swu_pkg::img_row_t'(STRIDE);
                        base_slot <= next_base;
                     end
                  end
               end
            end
         end
      end
   end

endmodule

/* source/swu_top.sv */
`timescale 1ns/1ps

module swu_top (
   input  logic                clk,
   input  logic                resetn,
   input  swu_pkg::data_word_t in_data_i,
   input  logic                in_valid_i,
   output logic                in_ready_o,
   output swu_pkg::data_word_t out_data_o,
   output logic                out_valid_o,
   input  logic                out_ready_i
);

   logic                wr_en;
   swu_pkg::buf_addr_t  wr_addr;
   swu_pkg::data_word_t wr_data;
   swu_pkg::img_row_t   rows_written;
   swu_pkg::img_row_t   oldest_row;
   logic                frame_done;
   swu_pkg::rd_issue_t  rd_issue;
   swu_pkg::data_word_t rd_data;
   logic                issue_ok;

   swu_write_ctrl u_write_ctrl (
      .clk            (clk),
      .resetn         (resetn),
      .in_data_i      (in_data_i),
      .in_valid_i     (in_valid_i),
      .in_ready_o     (in_ready_o),
      .wr_en_o        (wr_en),
      .wr_addr_o      (wr_addr),
      .wr_data_o      (wr_data),
      .rows_written_o (rows_written),
      .oldest_row_i   (oldest_row),
      .frame_done_i   (frame_done)
   );

   swu_window_buffer u_window_buffer (
      .clk        (clk),
      .wr_en_i    (wr_en),
      .wr_addr_i  (wr_addr),
      .wr_data_i  (wr_data),
      .rd_issue_i (rd_issue),
      .rd_data_o  (rd_data)
   );

   swu_read_ctrl u_read_ctrl (
      .clk            (clk),
      .resetn         (resetn),
      .rows_written_i (rows_written),
      .issue_ok_i     (issue_ok),
      .rd_issue_o     (rd_issue),
      .oldest_row_o   (oldest_row),
      .frame_done_o   (frame_done)
   );

   swu_out_stage u_out_stage (
      .clk         (clk),
      .resetn      (resetn),
      .rd_issue_i  (rd_issue),
      .rd_data_i   (rd_data),
      .issue_ok_o  (issue_ok),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

endmodule

/* source/swu_window_buffer.sv */
`timescale 1ns/1ps
`include "swu_config.svh"

module swu_window_buffer (
   input  logic                clk,
   input  logic                wr_en_i,
   input  swu_pkg::buf_addr_t  wr_addr_i,
   input  swu_pkg::data_word_t wr_data_i,
   input  swu_pkg::rd_issue_t  rd_issue_i,
   output swu_pkg::data_word_t rd_data_o
);

   // kernel height rows of image width times channels words
   swu_pkg::data_word_t mem [`SWU_BUF_WORDS];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // output register only loads on an issued read
   always_ff @(posedge clk) begin
      if (rd_issue_i.valid) begin
         rd_data_o <= mem[rd_issue_i.addr];
      end
   end

endmodule

/* source/swu_write_ctrl.sv */
`timescale 1ns/1ps
`include "swu_config.svh"

module swu_write_ctrl (
   input  logic                clk,
   input  logic                resetn,
   input  swu_pkg::data_word_t in_data_i,
   input  logic                in_valid_i,
   output logic                in_ready_o,
   output logic                wr_en_o,
   output swu_pkg::buf_addr_t  wr_addr_o,
   output swu_pkg::data_word_t wr_data_o,
   output swu_pkg::img_row_t   rows_written_o,
   input  swu_pkg::img_row_t   oldest_row_i,
   input  logic                frame_done_i
);

   localparam int KH        = `SWU_KERNEL_H;
   localparam int CH        = `SWU_CHANNELS;
   localparam int ROW_WORDS = `SWU_IFM_WIDTH * `SWU_CHANNELS;

   swu_pkg::wr_state_t state;
   swu_pkg::chan_t     chan;
   swu_pkg::img_col_t  col;
   swu_pkg::img_row_t  img_row;
   swu_pkg::row_slot_t row_slot;
   logic               rd_done;
   logic               xfer;
   logic               last_chan;
   logic               last_col;
   logic               last_row;
   logic               row_end;

   ////////////////////
   // handshake and row release

   // once the reader is done with the frame, trailing rows need no slot check
   assign in_ready_o = (state == swu_pkg::FILL) &&
                       (rd_done || (int'(img_row) < int'(oldest_row_i) + KH));

   assign xfer      = in_valid_i && in_ready_o;
   assign last_chan = (chan == swu_pkg::chan_t'(CH - 1));
   assign last_col  = (col == swu_pkg::img_col_t'(`SWU_IFM_WIDTH - 1));
   assign last_row  = (img_row == swu_pkg::img_row_t'(`SWU_IFM_HEIGHT - 1));
   assign row_end   = xfer && last_chan && last_col;

   assign wr_en_o   = xfer;
   assign wr_data_o = in_data_i;
   assign wr_addr_o = swu_pkg::buf_addr_t'(int'(row_slot) * ROW_WORDS +
                                           int'(col) * CH + int'(chan));

   // reader already moved to the next frame
   assign rows_written_o = rd_done ? '0 : img_row;

   ////////////////////
   // counters and FSM

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state    <= swu_pkg::FILL;
         chan     <= '0;
         col      <= '0;
         img_row  <= '0;
         row_slot <= '0;
         rd_done  <= 1'b0;
      end else begin
         case (state)
            swu_pkg::FILL: begin
               if (xfer) begin
                  chan <= last_chan ? '0 : chan + 1'b1;
                  if (last_chan) begin
                     col <= last_col ? '0 : col + 1'b1;
                  end
               end
               if (row_end) begin
                  if (last_row) begin
                     row_slot <= '0;
                     if (rd_done || frame_done_i) begin
                        img_row <= '0;
                        rd_done <= 1'b0;
                     end else begin
                        img_row <= img_row + 1'b1;
                        state   <= swu_pkg::WAIT_FRAME;
                     end
                  end else begin
                     img_row  <= img_row + 1'b1;
                     row_slot <= (row_slot == swu_pkg::row_slot_t'(KH - 1)) ?
                                 '0 : row_slot + 1'b1;
                  end
               end else if (frame_done_i) begin
                  rd_done <= 1'b1;
               end
            end
            swu_pkg::WAIT_FRAME: begin
               if (frame_done_i) begin
                  state   <= swu_pkg::FILL;
                  img_row <= '0;
               end
            end
            default: state <= swu_pkg::FILL;
         endcase
      end
   end

endmodule

/* tb.f */
+incdir+source
source/swu_pkg.sv
source/swu_write_ctrl.sv
source/swu_window_buffer.sv
source/swu_read_ctrl.sv
source/swu_out_stage.sv
source/swu_top.sv
tb/tb_clock_gen.sv
tb/tb_swu.sv

/* tb/swu_cases.txt */
# columns: case number, base (hex), step (hex), input gap percent, output stall percent
# every case sends two frames back to back, the second with its own base value
1  00 01  0  0
2  10 03  0 30
3  20 05  0 70
4  00 01 30  0
5  7f 0b 60  0
6  a5 07 25 25
7  ff ff 50 50
8  33 02 10 80
9  01 11 80 10
10 c3 fd 40 40
11 5a 13  0  0
12 e0 09 90 90

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int HALF_PERIOD  = 4,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic resetn
);

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   initial begin
      resetn = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      resetn <= 1'b1;
   end

endmodule

/* tb/tb_swu.sv */
`timescale 1ns/1ps
`include "swu_config.svh"

module tb_swu;

   localparam int W          = `SWU_IFM_WIDTH;
   localparam int H          = `SWU_IFM_HEIGHT;
   localparam int C          = `SWU_CHANNELS;
   localparam int KH         = `SWU_KERNEL_H;
   localparam int KW         = `SWU_KERNEL_W;
   localparam int S          = `SWU_STRIDE;
   localparam int OW         = `SWU_OFM_WIDTH;
   localparam int OH         = `SWU_OFM_HEIGHT;
   localparam int IN_WORDS   = H * W * C;
   localparam int OUT_WORDS  = OH * OW * KH * KW * C;
   localparam int FILL_WORDS = KH * W * C;
   localparam int FRAMES     = 2;
   localparam int IDLE_LIMIT = 2000;

   logic                clk;
   logic                resetn;
   swu_pkg::data_word_t in_data;
   logic                in_valid;
   logic                in_ready;
   swu_pkg::data_word_t out_data;
   logic                out_valid;
   logic                out_ready;

   int    seed = 60;
   int    checks;
   int    errors;
   int    tests;
   int    failed;
   int    fd;
   int    got;
   int    case_num;
   int    base_v;
   int    step_v;
   int    gap_pct;
   int    stall_pct;
   int    err_before;
   logic  timed_out;
   logic  file_error;
   string line;

   tb_clock_gen #(.HALF_PERIOD(4), .RESET_CYCLES(3)) u_clock_gen (
      .clk    (clk),
      .resetn (resetn)
   );

   swu_top UUT (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data),
      .in_valid_i  (in_valid),
      .in_ready_o  (in_ready),
      .out_data_o  (out_data),
      .out_valid_o (out_valid),
      .out_ready_i (out_ready)
   );

   ////////////////////
   // reference model

   function automatic swu_pkg::data_word_t input_word(input swu_pkg::data_word_t base,
                                                      input swu_pkg::data_word_t step,
                                                      input int k);
      return swu_pkg::data_word_t'(int'(base) + int'(step) * k);
   endfunction

   // each frame of a case starts from its own base value
   function automatic swu_pkg::data_word_t frame_base(input swu_pkg::data_word_t base,
                                                      input int frame);
      return swu_pkg::data_word_t'(int'(base) + 90 * frame);
   endfunction

   // idx counts channel fastest, then kernel col, kernel row, output col, output row
   function automatic swu_pkg::data_word_t window_word(input swu_pkg::data_word_t base,
                                                       input swu_pkg::data_word_t step,
                                                       input int idx);
      int ch;
      int kc;
      int kr;
      int oc;
      int orow;
      int rest;
      ch   = idx % C;
      rest = idx / C;
      kc   = rest % KW;
      rest = rest / KW;
      kr   = rest % KH;
      rest = rest / KH;
      oc   = rest % OW;
      orow = rest / OW;
      return input_word(base, step, ((orow * S + kr) * W + oc * S + kc) * C + ch);
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
                  $time, name, expected, actual);
      end
   endtask

   task automatic wait_for_reset();
      int cycles;
      cycles = 0;
      while (resetn !== 1'b1 && cycles < 100) begin
         @(posedge clk);
         cycles++;
      end
      if (resetn !== 1'b1) begin
         $display("timeout: reset was never released");
         timed_out = 1'b1;
      end
   endtask

   ////////////////////
   // one case, FRAMES frames back to back

   task automatic run_case(input swu_pkg::data_word_t base, input swu_pkg::data_word_t step,
                           input int in_gap, input int out_stall);
      int                  in_k;
      int                  out_k;
      int                  idle;
      int                  roll;
      logic                in_fire;
      logic                out_fire;
      logic                stalled;
      swu_pkg::data_word_t held;
      in_k    = 0;
      out_k   = 0;
      idle    = 0;
      stalled = 1'b0;
      held    = '0;
      @(posedge clk);
      roll = $unsigned($random(seed)) % 100;
      in_valid <= (roll >= in_gap);
      in_data  <= input_word(frame_base(base, 0), step, 0);
      roll = $unsigned($random(seed)) % 100;
      out_ready <= (roll >= out_stall);
      while (out_k < FRAMES * OUT_WORDS && !timed_out) begin
         @(negedge clk);
         in_fire  = in_valid && in_ready;
         out_fire = out_valid && out_ready;
         // a stalled word must not change
         if (stalled) begin
            check_value("out_valid_o", 32'(1'b1), 32'(out_valid));
            check_value("out_data_o", 32'(held), 32'(out_data));
         end
         if (in_k < FILL_WORDS) begin
            check_value("out_valid_o", 32'(1'b0), 32'(out_valid));
         end
         // at most two issued words are still in flight, so the frame is not yet fully issued
         if (in_k > 0 && in_k % IN_WORDS == 0 &&
             out_k + 2 < (in_k / IN_WORDS) * OUT_WORDS) begin
            check_value("in_ready_o", 32'(1'b0), 32'(in_ready));
         end
         if (out_fire) begin
            check_value("out_data_o",
                        32'(window_word(frame_base(base, out_k / OUT_WORDS), step,
                                        out_k % OUT_WORDS)),
                        32'(out_data));
            out_k++;
            idle = 0;
         end else begin
            idle++;
         end
         if (in_fire) begin
            in_k++;
         end
         stalled = out_valid && !out_ready;
         held    = out_data;
         if (idle > IDLE_LIMIT) begin
            $display("timeout: no output word arrived for %0d cycles after word %0d",
                     IDLE_LIMIT, out_k);
            timed_out = 1'b1;
         end else begin
            @(posedge clk);
            if (in_k >= FRAMES * IN_WORDS) begin
               in_valid <= 1'b0;
            end else if (!in_valid || in_fire) begin
               roll = $unsigned($random(seed)) % 100;
               in_valid <= (roll >= in_gap);
               in_data  <= input_word(frame_base(base, in_k / IN_WORDS), step,
                                      in_k % IN_WORDS);
            end
            roll = $unsigned($random(seed)) % 100;
            out_ready <= (roll >= out_stall);
         end
      end
      if (!timed_out) begin
         check_value("input words", 32'(FRAMES * IN_WORDS), 32'(in_k));
         // nothing may follow the last window word
         repeat (16) begin
            @(posedge clk);
            in_valid  <= 1'b0;
            out_ready <= 1'b1;
            @(negedge clk);
            check_value("out_valid_o", 32'(1'b0), 32'(out_valid));
         end
      end
   endtask

   ////////////////////
   // main sequence

   initial begin
      in_valid   = 1'b0;
      in_data    = '0;
      out_ready  = 1'b0;
      checks     = 0;
      errors     = 0;
      tests      = 0;
      failed     = 0;
      timed_out  = 1'b0;
      file_error = 1'b0;
      wait_for_reset();
      // input side is ready right after reset
      if (!timed_out) begin
         @(negedge clk);
         check_value("in_ready_o", 32'(1'b1), 32'(in_ready));
      end
      fd = $fopen("tb/swu_cases.txt", "r");
      if (fd == 0) begin
         $display("could not open the case file tb/swu_cases.txt");
         file_error = 1'b1;
      end else begin
         while (!$feof(fd) && !timed_out) begin
            line = "";
            got  = $fgets(line, fd);
            // comment and blank lines do not scan as five fields
            if (got > 0 && $sscanf(line, "%d %h %h %d %d", case_num, base_v, step_v,
                                   gap_pct, stall_pct) == 5) begin
               err_before = errors;
               run_case(swu_pkg::data_word_t'(base_v), swu_pkg::data_word_t'(step_v),
                        gap_pct, stall_pct);
               tests++;
               if (errors != err_before || timed_out) begin
                  failed++;
                  $display("case %0d: FAILED, %0d errors", case_num, errors - err_before);
               end else begin
                  $display("case %0d: ok, in gap %0d%%, out stall %0d%%",
                           case_num, gap_pct, stall_pct);
               end
            end
         end
         $fclose(fd);
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
      if (errors == 0 && failed == 0 && tests > 0 && !timed_out && !file_error) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule
